/* Bender.yml */
package:
  name: river

sources:
  - design/river_pkg.sv
  - design/log_renderer.sv
  - design/log_motion.sv
  - design/scan_producer.sv
  - design/pixel_fifo.sv
  - design/pixel_out.sv
  - design/river_top.sv
  - target: test
    files:
      - verification/river_tb.sv

/* design/log_motion.sv */
`default_nettype none

module log_motion import river_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      frame_done,
    output lane_pos_t log_x [NUM_LANES]
);

    logic [9:0] offset [NUM_LANES][LOGS_PER_LANE];

    // one frame step, modulo the playfield width
    function automatic logic [9:0] step_offset(
        input logic [9:0] off,
        input logic [9:0] spd,
        input move_dir_e  dir
    );
        logic [10:0] sum;
        sum = {1'b0, off} + {1'b0, spd};
        if (dir == DIR_RIGHT) begin
            return (sum >= {1'b0, PLAY_WIDTH}) ? 10'(sum - {1'b0, PLAY_WIDTH}) : sum[9:0];
        end
        return (off >= spd) ? (off - spd) : (off + PLAY_WIDTH - spd);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                for (int j = 0; j < LOGS_PER_LANE; j++) begin
                    offset[k][j] <= LOG_START_OFFSET[k][j];
                end
            end
        end else if (frame_done) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                for (int j = 0; j < LOGS_PER_LANE; j++) begin
                    offset[k][j] <= step_offset(offset[k][j], LANE_SPEED[k], LANE_DIR[k]);
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            for (int j = 0; j < LOGS_PER_LANE; j++) begin
                log_x[k].x[j] = X_OFFSET_LEFT + offset[k][j];
            end
        end
    end

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane_chk
        for (genvar j = 0; j < LOGS_PER_LANE; j++) begin : g_log_chk
            a_offset_range: assert property (@(posedge clk) disable iff (!rst_n)
                offset[k][j] < PLAY_WIDTH);
        end
    end

endmodule

`default_nettype wire

/* design/log_renderer.sv */
`default_nettype none

module log_renderer import river_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  pixel_req_t req,
    input  lane_pos_t  log_x [NUM_LANES],
    output logic       out_valid,
    output pixel_t     out_pixel
);

    logic                 in_play;
    logic [NUM_LANES-1:0] in_lane;
    logic                 hit;

    // logs only show between the playfield borders
    assign in_play = (req.col >= X_OFFSET_LEFT) && (req.col < X_OFFSET_RIGHT);

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            in_lane[k] = (req.row >= 10'((k + 1) * BLOCKSIZE)) &&
                         (req.row < 10'((k + 2) * BLOCKSIZE));
        end
    end

    always_comb begin
        logic [10:0] log_end;
        hit = 1'b0;
        log_end = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            for (int j = 0; j < LOGS_PER_LANE; j++) begin
                // one bit wider so a log hanging past the edge cannot wrap
                log_end = {1'b0, log_x[k].x[j]} + {1'b0, LANE_LOG_LENGTH[k]};
                if (in_play && in_lane[k] &&
                    (req.col >= log_x[k].x[j]) &&
                    ({1'b0, req.col} < log_end)) begin
                    hit = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            out_pixel.col   <= req.col;
            out_pixel.row   <= req.row;
            out_pixel.last  <= req.last;
            out_pixel.color <= hit ? COLOR_LOG_BODY : COLOR_WATER;
        end
    end

endmodule

`default_nettype wire

/* design/pixel_fifo.sv */
`default_nettype none

module pixel_fifo import river_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  pixel_t push_pixel,
    input  logic   pop,
    output logic   empty,
    output pixel_t head,
    output logic   credit_return
);

    pixel_t              mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic                full;

    assign empty = (count == '0);
    assign full  = (count == CREDIT_W'(FIFO_DEPTH));
    assign head  = mem[rd_ptr];

    // every entry leaving hands one credit back to the producer
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

/* design/pixel_out.sv */
`default_nettype none

module pixel_out import river_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   empty,
    input  pixel_t head,
    output logic   pop,
    output logic   pixel_valid,
    output pixel_t pixel,
    input  logic   pixel_ready,
    output logic   frame_done
);

    // refill when the register is free or drains this cycle
    assign pop = !empty && (!pixel_valid || pixel_ready);

    assign frame_done = pixel_valid && pixel_ready && pixel.last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
        end else if (pop) begin
            pixel_valid <= 1'b1;
        end else if (pixel_ready) begin
            pixel_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pixel <= head;
        end
    end

    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel));

endmodule

`default_nettype wire

/* design/river_pkg.sv */
`default_nettype none

package river_pkg;

    localparam logic [9:0] BLOCKSIZE      = 10'd32;
    localparam logic [9:0] X_OFFSET_LEFT  = 10'd96;
    localparam logic [9:0] X_OFFSET_RIGHT = 10'd544;
    localparam logic [9:0] PLAY_WIDTH     = X_OFFSET_RIGHT - X_OFFSET_LEFT;

    localparam logic [9:0] FRAME_COLS = 10'd640;
    localparam logic [9:0] FRAME_ROWS = 10'd256;

    localparam int NUM_LANES     = 6;
    localparam int LOGS_PER_LANE = 3;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    localparam logic [5:0] COLOR_LOG_BODY = 6'b100010;
    localparam logic [5:0] COLOR_WATER    = 6'b000000;

    typedef enum logic {
        DIR_LEFT,
        DIR_RIGHT
    } move_dir_e;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_WAIT_FRAME
    } scan_state_e;

    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       last;
    } pixel_req_t;

    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       last;
        logic [5:0] color;
    } pixel_t;

    // screen x of each log in one lane
    typedef struct packed {
        logic [LOGS_PER_LANE-1:0][9:0] x;
    } lane_pos_t;

    localparam logic [9:0] LANE_LOG_LENGTH [NUM_LANES] =
        '{10'd96, 10'd64, 10'd128, 10'd64, 10'd96, 10'd128};

    localparam logic [9:0] LANE_SPEED [NUM_LANES] =
        '{10'd1, 10'd2, 10'd3, 10'd1, 10'd2, 10'd3};

    localparam move_dir_e LANE_DIR [NUM_LANES] =
        '{DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_LEFT};

    // offsets from the left playfield edge
    // some logs start next to a wrap point
    localparam logic [9:0] LOG_START_OFFSET [NUM_LANES][LOGS_PER_LANE] = '{
        '{10'd0,   10'd150, 10'd400},
        '{10'd1,   10'd160, 10'd300},
        '{10'd150, 10'd300, 10'd446},
        '{10'd60,  10'd200, 10'd340},
        '{10'd20,  10'd180, 10'd330},
        '{10'd0,   10'd150, 10'd300}
    };

endpackage

`default_nettype wire

/* design/river_top.sv */
`default_nettype none

module river_top import river_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   run,
    input  logic   pixel_ready,
    output logic   pixel_valid,
    output pixel_t pixel,
    output logic   frame_done
);

    lane_pos_t log_x [NUM_LANES];
    logic      push;
    pixel_t    push_pixel;
    logic      pop;
    logic      empty;
    pixel_t    head;
    logic      credit_return;

    log_motion u_motion (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_done (frame_done),
        .log_x      (log_x)
    );

    scan_producer u_producer (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .log_x         (log_x),
        .frame_done    (frame_done),
        .credit_return (credit_return),
        .push          (push),
        .push_pixel    (push_pixel)
    );

    pixel_fifo u_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_pixel    (push_pixel),
        .pop           (pop),
        .empty         (empty),
        .head          (head),
        .credit_return (credit_return)
    );

    pixel_out u_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty       (empty),
        .head        (head),
        .pop         (pop),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_ready (pixel_ready),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

/* design/scan_producer.sv */
`default_nettype none

module scan_producer import river_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  lane_pos_t log_x [NUM_LANES],
    input  logic      frame_done,
    input  logic      credit_return,
    output logic      push,
    output pixel_t    push_pixel
);

    scan_state_e         state;
    logic [9:0]          col;
    logic [9:0]          row;
    logic [CREDIT_W-1:0] credits;
    logic                issue;
    logic                at_last;
    pixel_req_t          req;

    assign issue   = (state == SCAN_RUN) && (credits != '0);
    assign at_last = (col == FRAME_COLS - 10'd1) && (row == FRAME_ROWS - 10'd1);

    always_comb begin
        req.col  = col;
        req.row  = row;
        req.last = at_last;
    end

    // counters wrap to zero after the last pixel, ready for the next frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SCAN_IDLE;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (run) begin
                        state <= SCAN_RUN;
                    end
                end
                SCAN_RUN: begin
                    if (issue) begin
                        if (at_last) begin
                            state <= SCAN_WAIT_FRAME;
                        end
                        if (col == FRAME_COLS - 10'd1) begin
                            col <= '0;
                            row <= (row == FRAME_ROWS - 10'd1) ? 10'd0 : row + 10'd1;
                        end else begin
                            col <= col + 10'd1;
                        end
                    end
                end
                SCAN_WAIT_FRAME: begin
                    if (frame_done) begin
                        state <= run ? SCAN_RUN : SCAN_IDLE;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            case ({issue, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    log_renderer u_renderer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (issue),
        .req       (req),
        .log_x     (log_x),
        .out_valid (push),
        .out_pixel (push_pixel)
    );

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* river.f */
design/river_pkg.sv
design/log_renderer.sv
design/log_motion.sv
design/scan_producer.sv
design/pixel_fifo.sv
design/pixel_out.sv
design/river_top.sv
verification/river_tb.sv

/* verification/river_tb.sv */
`default_nettype none

module river_tb import river_pkg::*;;

    localparam int     PIXELS_PER_FRAME = 163840;
    localparam longint WATCHDOG_TIME    = 3 * PIXELS_PER_FRAME * 4 * 20 + 1000000;

    logic   clk;
    logic   rst_n;
    logic   run;
    logic   pixel_ready;
    logic   pixel_valid;
    pixel_t pixel;
    logic   frame_done;

    logic       xfer;
    logic       at_frame_end;
    logic       expect_quiet;
    logic [5:0] exp_color;
    int         exp_col;
    int         exp_row;
    int         frames_seen;
    int         ref_off [NUM_LANES][LOGS_PER_LANE];
    int         errors;
    int         tests_passed;
    int         tests_failed;
    int         seed = 55180;
    int         rnd;

    river_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .pixel_ready (pixel_ready),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .frame_done  (frame_done)
    );

    always #10 clk = ~clk;

    assign xfer         = pixel_valid && pixel_ready;
    assign at_frame_end = (exp_col == FRAME_COLS - 1) && (exp_row == FRAME_ROWS - 1);

    // each offset moves by its lane speed and wraps inside the playfield
    function automatic int next_offset(input int off, input int k);
        int spd;
        int width;
        spd = int'(LANE_SPEED[k]);
        width = int'(PLAY_WIDTH);
        if (LANE_DIR[k] == DIR_RIGHT) begin
            return (off + spd) % width;
        end
        return (off - spd + width) % width;
    endfunction

    // expected color at the next raster position
    always_comb begin
        int lane;
        int x;
        lane = 0;
        x = 0;
        exp_color = COLOR_WATER;
        if (exp_row >= int'(BLOCKSIZE) && exp_row < (NUM_LANES + 1) * int'(BLOCKSIZE) &&
            exp_col >= int'(X_OFFSET_LEFT) && exp_col < int'(X_OFFSET_RIGHT)) begin
            lane = exp_row / int'(BLOCKSIZE) - 1;
            for (int j = 0; j < LOGS_PER_LANE; j++) begin
                x = int'(X_OFFSET_LEFT) + ref_off[lane][j];
                if (exp_col >= x && exp_col < x + int'(LANE_LOG_LENGTH[lane])) begin
                    exp_color = COLOR_LOG_BODY;
                end
            end
        end
    end

    // reference scan position and log offsets
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_col <= 0;
            exp_row <= 0;
            frames_seen <= 0;
            for (int k = 0; k < NUM_LANES; k++) begin
                for (int j = 0; j < LOGS_PER_LANE; j++) begin
                    ref_off[k][j] <= int'(LOG_START_OFFSET[k][j]);
                end
            end
        end else begin
            if (xfer) begin
                if (exp_col == FRAME_COLS - 1) begin
                    exp_col <= 0;
                    exp_row <= (exp_row == FRAME_ROWS - 1) ? 0 : exp_row + 1;
                end else begin
                    exp_col <= exp_col + 1;
                end
            end
            if (frame_done) begin
                frames_seen <= frames_seen + 1;
                for (int k = 0; k < NUM_LANES; k++) begin
                    for (int j = 0; j < LOGS_PER_LANE; j++) begin
                        ref_off[k][j] <= next_offset(ref_off[k][j], k);
                    end
                end
            end
        end
    end

    // the sink accepts about three cycles out of four
    always @(posedge clk) begin
        rnd = $random(seed);
        pixel_ready <= (rnd[1:0] != 2'b00);
    end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        expect_quiet |-> !pixel_valid && !frame_done)
        else begin
            $display("[ERROR] %0t: output active while idle", $time);
            errors++;
        end

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> pixel.col == exp_col && pixel.row == exp_row)
        else begin
            $display("[ERROR] %0t: got pixel (%0d,%0d), expected (%0d,%0d)",
                     $time, pixel.col, pixel.row, exp_col, exp_row);
            errors++;
        end

    a_last: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> pixel.last == at_frame_end)
        else begin
            $display("[ERROR] %0t: last flag %0b wrong at (%0d,%0d)",
                     $time, pixel.last, pixel.col, pixel.row);
            errors++;
        end

    a_color: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> pixel.color == exp_color)
        else begin
            $display("[ERROR] %0t: color %h at (%0d,%0d), expected %h",
                     $time, pixel.color, pixel.col, pixel.row, exp_color);
            errors++;
        end

    a_frame_done: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done == (xfer && at_frame_end))
        else begin
            $display("[ERROR] %0t: frame_done %0b at (%0d,%0d)",
                     $time, frame_done, exp_col, exp_row);
            errors++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel))
        else begin
            $display("[ERROR] %0t: pixel changed while stalled", $time);
            errors++;
        end

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int mark;
        clk = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        pixel_ready = 1'b0;
        expect_quiet = 1'b1;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        mark = errors;
        repeat (40) @(posedge clk);
        report_test("reset and idle", mark);

        mark = errors;
        expect_quiet <= 1'b0;
        run <= 1'b1;
        wait (frames_seen == 1);
        @(posedge clk);
        report_test("frame 0 unmoved logs", mark);

        mark = errors;
        wait (frames_seen == 2);
        // producer has already restarted, so this frame is the last one
        @(posedge clk);
        run <= 1'b0;
        report_test("frame 1 moved logs", mark);

        mark = errors;
        wait (frames_seen == 3);
        @(posedge clk);
        report_test("frame 2 moved logs", mark);

        mark = errors;
        repeat (2) @(posedge clk);
        expect_quiet <= 1'b1;
        repeat (200) @(posedge clk);
        if (frames_seen != 3) begin
            $display("saw %0d frames after run dropped, expected 3", frames_seen);
            errors++;
        end
        report_test("idle after run drops", mark);

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the frames did not complete in time, %0d seen", frames_seen);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
